// File: logic/llc_pkg.sv
package llc_pkg;

    localparam int sets        = 16;                       // Sets in the cache
    localparam int ways        = 4;                        // Associativity
    localparam int addr_bits   = 16;                       // Byte address width
    localparam int offset_bits = 4;                        // 16-byte lines
    localparam int index_bits  = $clog2(sets);             // Set index width
    localparam int tag_bits    = addr_bits - index_bits - offset_bits;
    localparam int fifo_depth  = 4;                        // Result FIFO entries

    typedef logic [addr_bits-1:0]     addr_t;              // Byte address
    typedef logic [index_bits-1:0]    index_t;             // Set index
    typedef logic [tag_bits-1:0]      tag_t;               // Line tag
    typedef logic [$clog2(ways)-1:0]  age_t;               // LRU age, 0 is newest
    typedef logic [$clog2(ways)-1:0]  way_t;               // Way number

    typedef enum logic [1:0] {
        invalid,
        shared,
        exclusive,
        modified
    } mesi_e;

    // Trace command codes
    typedef enum logic [3:0] {
        rd      = 4'd0,                                    // Data read
        wr      = 4'd1,                                    // Data write
        ifetch  = 4'd2,                                    // Instruction fetch
        snp_inv = 4'd3,                                    // Snooped invalidate
        snp_rd  = 4'd4,                                    // Snooped read
        clear   = 4'd8                                     // Reset all lines
    } cmd_op_e;

    typedef enum logic [1:0] {
        bus_none,
        bus_read,
        bus_rwitm,
        bus_invalidate
    } bus_op_e;

    typedef struct packed {
        cmd_op_e op;
        addr_t   addr;
    } cmd_t;                                               // 20 bits

    typedef struct packed {
        tag_t  tag;
        age_t  age;
        mesi_e mesi;
    } line_t;

    typedef line_t [ways-1:0] set_t;                       // Whole set as one word

    typedef struct packed {
        cmd_op_e op;
        index_t  index;
        logic    hit;
        way_t    way;                                      // Way touched or filled
        mesi_e   new_mesi;
        bus_op_e bus_op;
        logic    writeback;                                // Modified data leaves the cache
        tag_t    evict_tag;
    } result_t;

endpackage

// File: logic/cmd_intake.sv
module cmd_intake (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cmd_valid,
    input  llc_pkg::cmd_t    cmd,
    input  logic             req_done,
    output logic             cmd_ready,
    output logic             req_valid,
    output llc_pkg::cmd_op_e req_op,
    output llc_pkg::index_t  req_index,
    output llc_pkg::tag_t    req_tag
);
    import llc_pkg::*;

    logic    held;                                         // Holding register occupied
    logic    accept;                                       // Handshake this cycle
    logic    op_known;                                     // Opcode is one we act on
    cmd_op_e op_q;
    index_t  index_q;
    tag_t    tag_q;

    // Codes without meaning are swallowed here and never reach the engine
    always_comb begin
        case (cmd.op)
            rd, wr, ifetch, snp_inv, snp_rd, clear: op_known = 1'b1;
            default:                                op_known = 1'b0;
        endcase
    end

    assign cmd_ready = !held;                              // Ready only when empty
    assign accept    = cmd_valid && cmd_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= 1'b0;
        end else if (accept && op_known) begin
            held <= 1'b1;                                  // Busy until engine is done
        end else if (req_done) begin
            held <= 1'b0;
        end
    end

    // Address split, offset bits are dropped
    always_ff @(posedge clk) begin
        if (accept && op_known) begin
            op_q    <= cmd.op;
            index_q <= cmd.addr[offset_bits +: index_bits];
            tag_q   <= cmd.addr[addr_bits-1 -: tag_bits];
        end
    end

    assign req_valid = held;
    assign req_op    = op_q;
    assign req_index = index_q;
    assign req_tag   = tag_q;

endmodule

// File: logic/cache_array.sv
module cache_array (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rd_en,
    input  llc_pkg::index_t rd_index,
    input  logic            wr_en,
    input  llc_pkg::index_t wr_index,
    input  llc_pkg::set_t   wr_set,
    input  logic            clear_start,
    output llc_pkg::set_t   rd_set,
    output logic            clear_busy
);
    import llc_pkg::*;

    set_t   mem [sets];                                    // One word per set
    set_t   clr_set;                                       // Contents of a freshly cleared set
    index_t clr_idx;                                       // Sweep position
    logic   sweeping;

    // Every line Invalid, tag 0, age equal to its way
    always_comb begin
        for (int w = 0; w < ways; w++) begin
            clr_set[w].tag  = '0;
            clr_set[w].age  = age_t'(w);
            clr_set[w].mesi = invalid;
        end
    end

    // Sweep control, one set per cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sweeping <= 1'b0;
            clr_idx  <= '0;
        end else if (clear_start) begin
            sweeping <= 1'b1;
            clr_idx  <= '0;
        end else if (sweeping) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == index_t'(sets - 1)) begin
                sweeping <= 1'b0;                          // Last set written this cycle
            end
        end
    end

    assign clear_busy = sweeping;

    // Storage write port, sweep and engine never overlap
    always_ff @(posedge clk) begin
        if (sweeping) begin
            mem[clr_idx] <= clr_set;
        end else if (wr_en) begin
            mem[wr_index] <= wr_set;
        end
    end

    // Synchronous read, output held between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_set <= mem[rd_index];
        end
    end

endmodule

// File: logic/mesi_lru_engine.sv
module mesi_lru_engine (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    input  llc_pkg::cmd_op_e req_op,
    input  llc_pkg::index_t  req_index,
    input  llc_pkg::tag_t    req_tag,
    input  llc_pkg::set_t    rd_set,
    input  logic             clear_busy,
    input  logic             full,
    output logic             req_done,
    output logic             rd_en,
    output llc_pkg::index_t  rd_index,
    output logic             wr_en,
    output llc_pkg::index_t  wr_index,
    output llc_pkg::set_t    wr_set,
    output logic             clear_start,
    output logic             push,
    output llc_pkg::result_t push_data
);
    import llc_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_read,                                           // Set data arriving
        st_update,                                         // Write back set and push
        st_clear,                                          // Array sweep running
        st_clear_done
    } state_e;

    state_e  state;
    state_e  state_nxt;
    logic    hit;
    way_t    hit_way;
    logic    have_inv;                                     // Some way is Invalid
    way_t    inv_way;                                      // Lowest Invalid way
    way_t    lru_way;                                      // Oldest way
    way_t    way_sel;
    logic    local_op;                                     // Access from this side, not a snoop
    line_t   old_line;
    set_t    set_nxt;
    result_t res_nxt;
    set_t    set_q;
    result_t res_q;

    // Tag compare and victim search
    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        have_inv = 1'b0;
        inv_way  = '0;
        lru_way  = '0;
        for (int w = ways - 1; w >= 0; w--) begin
            if (rd_set[w].mesi != invalid && rd_set[w].tag == req_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
            if (rd_set[w].mesi == invalid) begin
                have_inv = 1'b1;
                inv_way  = way_t'(w);                      // Last write is the lowest
            end
            if (rd_set[w].age == age_t'(ways - 1)) begin
                lru_way = way_t'(w);
            end
        end
    end

    assign local_op = (req_op == rd) || (req_op == wr) || (req_op == ifetch);
    assign way_sel  = hit ? hit_way : (have_inv ? inv_way : lru_way);
    assign old_line = rd_set[way_sel];

    // MESI transition, bus op and new set contents
    always_comb begin
        set_nxt            = rd_set;
        res_nxt.op         = req_op;
        res_nxt.index      = req_index;
        res_nxt.hit        = hit;
        res_nxt.way        = (hit || local_op) ? way_sel : '0;
        res_nxt.new_mesi   = hit ? old_line.mesi : invalid;
        res_nxt.bus_op     = bus_none;
        res_nxt.writeback  = 1'b0;
        res_nxt.evict_tag  = '0;
        case (req_op)
            rd, ifetch: begin
                if (!hit) begin
                    res_nxt.new_mesi = (req_op == rd) ? exclusive : shared;
                    res_nxt.bus_op   = bus_read;
                end
            end
            wr: begin
                res_nxt.new_mesi = modified;
                if (!hit) begin
                    res_nxt.bus_op = bus_rwitm;            // Fill with ownership
                end else if (old_line.mesi == shared) begin
                    res_nxt.bus_op = bus_invalidate;       // Upgrade, kill other copies
                end
            end
            snp_inv: begin
                if (hit) begin
                    res_nxt.new_mesi  = invalid;
                    res_nxt.writeback = (old_line.mesi == modified);
                end
            end
            snp_rd: begin
                if (hit && old_line.mesi != shared) begin
                    res_nxt.new_mesi  = shared;            // E or M drops to S
                    res_nxt.writeback = (old_line.mesi == modified);
                end
            end
            default: ;
        endcase
        if (local_op && !hit) begin
            res_nxt.writeback = (old_line.mesi == modified);  // Dirty victim leaves
            res_nxt.evict_tag = old_line.tag;
            set_nxt[way_sel].tag = req_tag;
        end
        if (hit || local_op) begin
            set_nxt[way_sel].mesi = res_nxt.new_mesi;
        end
        // Ages move on local accesses only
        if (local_op) begin
            for (int w = 0; w < ways; w++) begin
                if (rd_set[w].age < old_line.age) begin
                    set_nxt[w].age = rd_set[w].age + 1'b1;
                end
            end
            set_nxt[way_sel].age = '0;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:       if (req_valid) state_nxt = (req_op == clear) ? st_clear : st_read;
            st_read:       state_nxt = st_update;
            st_update:     if (!full) state_nxt = st_idle;
            st_clear:      if (!clear_busy) state_nxt = st_clear_done;
            st_clear_done: if (!full) state_nxt = st_idle;
            default:       state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Result and set captured once rd_set is valid
    always_ff @(posedge clk) begin
        if (state == st_read) begin
            set_q <= set_nxt;
            res_q <= res_nxt;
        end else if (clear_start) begin
            res_q <= '{op: clear, index: req_index, hit: 1'b0, way: '0, new_mesi: invalid,
                       bus_op: bus_none, writeback: 1'b0, evict_tag: '0};
        end
    end

    assign rd_en       = (state == st_idle) && req_valid && (req_op != clear);
    assign clear_start = (state == st_idle) && req_valid && (req_op == clear);
    assign rd_index    = req_index;
    assign wr_index    = req_index;                        // Intake holds it until done
    assign wr_set      = set_q;
    assign wr_en       = (state == st_update) && !full;
    assign push        = ((state == st_update) || (state == st_clear_done)) && !full;
    assign push_data   = res_q;
    assign req_done    = push;                             // Frees the intake register

endmodule

// File: logic/result_fifo.sv
module result_fifo (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  llc_pkg::result_t push_data,
    input  logic             res_ready,
    output logic             full,
    output logic             res_valid,
    output llc_pkg::result_t res
);
    import llc_pkg::*;

    result_t                         mem [fifo_depth];     // Result storage
    logic [$clog2(fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(fifo_depth)-1:0]   rd_ptr;
    logic [$clog2(fifo_depth):0]     count;                // Needs one extra bit for full
    logic                            do_push;
    logic                            do_pop;

    assign full      = (count == fifo_depth);
    assign res_valid = (count != 0);
    assign res       = mem[rd_ptr];                        // Head is always on the output
    assign do_push   = push && !full;
    assign do_pop    = res_valid && res_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;                   // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: logic/llc_top.sv
module llc_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cmd_valid,
    input  llc_pkg::cmd_t    cmd,
    input  logic             res_ready,
    output logic             cmd_ready,
    output logic             res_valid,
    output llc_pkg::result_t res
);
    import llc_pkg::*;

    logic    req_valid;                                    // Intake to engine
    cmd_op_e req_op;
    index_t  req_index;
    tag_t    req_tag;
    logic    req_done;
    logic    rd_en;                                        // Engine to array
    index_t  rd_index;
    set_t    rd_set;
    logic    wr_en;
    index_t  wr_index;
    set_t    wr_set;
    logic    clear_start;
    logic    clear_busy;
    logic    push;                                         // Engine to FIFO
    result_t push_data;
    logic    full;

    cmd_intake u_intake (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .req_done  (req_done),
        .cmd_ready (cmd_ready),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_index (req_index),
        .req_tag   (req_tag)
    );

    mesi_lru_engine u_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_index   (req_index),
        .req_tag     (req_tag),
        .rd_set      (rd_set),
        .clear_busy  (clear_busy),
        .full        (full),
        .req_done    (req_done),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_set      (wr_set),
        .clear_start (clear_start),
        .push        (push),
        .push_data   (push_data)
    );

    cache_array u_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_set      (wr_set),
        .clear_start (clear_start),
        .rd_set      (rd_set),
        .clear_busy  (clear_busy)
    );

    result_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .res_ready (res_ready),
        .full      (full),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

// File: tb/tb_llc.sv
module tb_llc;
    import llc_pkg::*;

    localparam int clk_period = 20;
    localparam int n_random   = 200;                       // Random commands after the directed part
    localparam int n_cmds     = n_random + 40;             // Directed part stays below 40
    localparam int wd_cycles  = n_cmds * 40 + 2 * (sets + 4) + 10;

    logic        clk;
    logic        rst_n;
    logic        cmd_valid;
    cmd_t        cmd;
    logic        res_ready;
    logic        cmd_ready;
    logic        res_valid;
    result_t     res;

    logic        res_take;                                 // Result handshake in this cycle
    logic        cmd_fire;                                 // Seen at the last edge
    logic        res_fire;
    logic [31:0] seed;
    int          stall;                                    // 0 always ready, 1 half, 2 rare
    int          errors;
    int          checked;
    int          pending;                                  // Expected results not yet taken
    result_t     exp_head;
    result_t     exp_q [$];
    tag_t        m_tag  [sets][ways];                      // Reference copy of the array
    age_t        m_age  [sets][ways];
    mesi_e       m_mesi [sets][ways];

    llc_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .res_ready (res_ready),
        .cmd_ready (cmd_ready),
        .res_valid (res_valid),
        .res       (res)
    );

    always #(clk_period / 2) clk = !clk;

    assign res_take = res_valid && res_ready;

    function automatic void flag_mismatch(input string name, input logic [31:0] got,
                                          input logic [31:0] exp);
        errors++;
        $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    endfunction

    function automatic void flag_failure(input string what);
        errors++;
        $display("Error: %s", what);
    endfunction

    // Checks sit on the falling edge, all signals are settled there
    assert property (@(negedge clk) disable iff (!rst_n) res_valid |-> pending != 0)
        else flag_failure("result offered while no command was outstanding");
    assert property (@(negedge clk) disable iff (!rst_n) pending > fifo_depth |-> !cmd_ready)
        else flag_failure("cmd_ready high while the FIFO is full and a command is held");
    assert property (@(negedge clk) disable iff (!rst_n) res_take |-> res.op == exp_head.op)
        else flag_mismatch("op", 32'(res.op), 32'(exp_head.op));
    assert property (@(negedge clk) disable iff (!rst_n) res_take |-> res.index == exp_head.index)
        else flag_mismatch("index", 32'(res.index), 32'(exp_head.index));
    assert property (@(negedge clk) disable iff (!rst_n) res_take |-> res.hit == exp_head.hit)
        else flag_mismatch("hit", 32'(res.hit), 32'(exp_head.hit));
    assert property (@(negedge clk) disable iff (!rst_n) res_take |-> res.way == exp_head.way)
        else flag_mismatch("way", 32'(res.way), 32'(exp_head.way));
    assert property (@(negedge clk) disable iff (!rst_n)
                     res_take |-> res.new_mesi == exp_head.new_mesi)
        else flag_mismatch("new_mesi", 32'(res.new_mesi), 32'(exp_head.new_mesi));
    assert property (@(negedge clk) disable iff (!rst_n) res_take |-> res.bus_op == exp_head.bus_op)
        else flag_mismatch("bus_op", 32'(res.bus_op), 32'(exp_head.bus_op));
    assert property (@(negedge clk) disable iff (!rst_n)
                     res_take |-> res.writeback == exp_head.writeback)
        else flag_mismatch("writeback", 32'(res.writeback), 32'(exp_head.writeback));
    assert property (@(negedge clk) disable iff (!rst_n)
                     res_take |-> res.evict_tag == exp_head.evict_tag)
        else flag_mismatch("evict_tag", 32'(res.evict_tag), 32'(exp_head.evict_tag));

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic cmd_op_e pick_op(input logic [31:0] r);
        case (r[18:16])
            3'd0, 3'd1: return rd;
            3'd2, 3'd3: return wr;
            3'd4:       return ifetch;
            3'd5:       return snp_inv;
            default:    return snp_rd;
        endcase
    endfunction

    // Tag above the set index, offset varies and must not matter
    function automatic addr_t mk_addr(input int t, input int i);
        return {tag_t'(t), index_t'(i), 4'(t + i)};
    endfunction

    function automatic void model_clear();
        for (int s = 0; s < sets; s++) begin
            for (int w = 0; w < ways; w++) begin
                m_tag[s][w]  = '0;
                m_age[s][w]  = age_t'(w);                  // Way 0 newest after a clear
                m_mesi[s][w] = invalid;
            end
        end
    endfunction

    // Expected result of one accepted command, model updated in place
    function automatic void predict(input cmd_t c);
        result_t r;
        index_t  s;
        tag_t    t;
        int      w;
        int      hw;
        age_t    a;
        mesi_e   old;
        s       = index_t'(c.addr >> 4);
        t       = tag_t'(c.addr >> (4 + index_bits));
        r       = '0;
        r.op    = c.op;
        r.index = s;
        if (c.op == clear) begin
            model_clear();
            exp_q.push_back(r);
            return;
        end
        if (!(c.op inside {rd, wr, ifetch, snp_inv, snp_rd})) begin
            return;                                        // Unknown code gives no result
        end
        hw = -1;
        for (int v = 0; v < ways; v++) begin
            if (hw < 0 && m_mesi[s][v] != invalid && m_tag[s][v] == t) begin
                hw = v;
            end
        end
        if (c.op inside {rd, wr, ifetch}) begin
            if (hw >= 0) begin
                w          = hw;
                old        = m_mesi[s][w];
                r.hit      = 1'b1;
                r.new_mesi = (c.op == wr) ? modified : old;
                r.bus_op   = (c.op == wr && old == shared) ? bus_invalidate : bus_none;
            end else begin
                w = -1;
                for (int v = 0; v < ways; v++) begin
                    if (w < 0 && m_mesi[s][v] == invalid) begin
                        w = v;                             // Lowest free way
                    end
                end
                for (int v = 0; v < ways; v++) begin
                    if (w < 0 && m_age[s][v] == age_t'(ways - 1)) begin
                        w = v;                             // Oldest way
                    end
                end
                r.writeback = (m_mesi[s][w] == modified);
                r.evict_tag = m_tag[s][w];
                r.new_mesi  = (c.op == rd) ? exclusive : ((c.op == ifetch) ? shared : modified);
                r.bus_op    = (c.op == wr) ? bus_rwitm : bus_read;
                m_tag[s][w] = t;
            end
            r.way        = way_t'(w);
            m_mesi[s][w] = r.new_mesi;
            a            = m_age[s][w];
            for (int v = 0; v < ways; v++) begin
                if (m_age[s][v] < a) begin
                    m_age[s][v] = m_age[s][v] + age_t'(1);
                end
            end
            m_age[s][w] = '0;
        end else if (hw >= 0) begin
            old         = m_mesi[s][hw];
            r.hit       = 1'b1;
            r.way       = way_t'(hw);
            r.new_mesi  = (c.op == snp_inv) ? invalid : shared;
            r.writeback = (old == modified);               // Dirty line goes to the bus
            m_mesi[s][hw] = r.new_mesi;
        end
        exp_q.push_back(r);
    endfunction

    // One clock, handshakes sampled mid cycle, new inputs 1 unit after the edge
    task automatic step();
        @(negedge clk);
        cmd_fire = cmd_valid && cmd_ready;
        res_fire = res_take;
        @(posedge clk);
        #1;
        if (res_fire && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            checked++;
        end
        if (cmd_fire) begin
            predict(cmd);
        end
        pending = exp_q.size();
        if (pending != 0) begin
            exp_head = exp_q[0];
        end
        seed = xorshift(seed);
        case (stall)
            0:       res_ready = 1'b1;
            1:       res_ready = seed[0];
            default: res_ready = (seed[2:0] == 3'd0);      // Long stalls fill the FIFO
        endcase
    endtask

    task automatic send(input cmd_op_e op, input addr_t addr);
        cmd_valid = 1'b1;
        cmd.op    = op;
        cmd.addr  = addr;
        do begin
            step();
        end while (!cmd_fire);
        cmd_valid = 1'b0;
    endtask

    initial begin
        #(wd_cycles * clk_period);
        $display("Timeout after %0d cycles, %0d results outstanding", wd_cycles, pending);
        $display("Regression failed");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        res_ready = 1'b1;
        seed      = 32'hb185;
        stall     = 0;
        errors    = 0;
        checked   = 0;
        pending   = 0;
        exp_head  = '0;
        cmd_fire  = 1'b0;
        res_fire  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (cmd_ready && !res_valid)
            else flag_failure("cmd_ready low or res_valid high right after reset");
        send(clear, '0);
        send(rd, mk_addr(1, 1));                           // Cold misses
        send(ifetch, mk_addr(1, 2));
        send(wr, mk_addr(1, 3));
        send(rd, mk_addr(1, 1));
        send(wr, mk_addr(1, 1));                           // E to M, silent
        send(ifetch, mk_addr(1, 2));
        send(wr, mk_addr(1, 2));                           // S to M, invalidate others
        send(rd, mk_addr(1, 3));
        for (int t = 0; t < ways + 2; t++) begin
            send((t % 2 == 1) ? wr : rd, mk_addr(t + 2, 5));
        end
        send(wr, mk_addr(1, 6));
        send(rd, mk_addr(2, 6));
        send(rd, mk_addr(3, 6));
        send(ifetch, mk_addr(4, 6));
        send(snp_rd, mk_addr(1, 6));                       // M supplies data
        send(snp_inv, mk_addr(2, 6));
        send(snp_rd, mk_addr(9, 6));
        send(snp_inv, mk_addr(9, 6));
        send(rd, mk_addr(5, 6));                           // Takes the freed way
        send(rd, mk_addr(6, 6));                           // LRU untouched by snoops
        send(cmd_op_e'(4'd9), mk_addr(1, 1));
        send(rd, mk_addr(1, 1));
        stall = 2;
        for (int i = 0; i < n_random; i++) begin
            if (i == n_random / 2) begin
                stall = 1;
                send(clear, mk_addr(0, 7));
            end
            seed = xorshift(seed);
            send(pick_op(seed), mk_addr(int'(seed[10:8]), int'(seed[13:12])));
        end
        stall = 0;
        while (pending != 0) begin
            step();
        end
        repeat (4) step();
        $display("Summary: %0d results checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: flist.f
logic/llc_pkg.sv
logic/cmd_intake.sv
logic/cache_array.sv
logic/mesi_lru_engine.sv
logic/result_fifo.sv
logic/llc_top.sv
tb/tb_llc.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the LLC testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_llc -f flist.f -o sim_llc

./obj_dir/sim_llc | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
